// File: include/csr_unit_cfg.svh
`ifndef CSR_UNIT_CFG_SVH
`define CSR_UNIT_CFG_SVH

// Register width
`define CSR_XLEN 32

// CSR address field of the instruction
`define CSR_ADDR_W 12

// cycle and time counters are 64 bits, read in two halves
`define CSR_COUNTER_W 64

// Clock edges per time tick
`define CSR_TIME_DIV 4

// MXL = 1 (RV32), extensions I and U
`define CSR_MISA_VALUE 32'h4010_0100

`endif

// File: verilog/csr_pkg.sv
package csr_pkg;

    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_W     = 3'd1,
        CMD_S     = 3'd2,
        CMD_C     = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_e;

    // Only user and machine levels exist
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_mode_e;

    typedef enum logic [11:0] {
        ADDR_MSTATUS  = 12'h300,
        ADDR_MISA     = 12'h301,
        ADDR_MIE      = 12'h304,
        ADDR_MTVEC    = 12'h305,
        ADDR_MSCRATCH = 12'h340,
        ADDR_MEPC     = 12'h341,
        ADDR_MCAUSE   = 12'h342,
        ADDR_MTVAL    = 12'h343,
        ADDR_MIP      = 12'h344,
        ADDR_MCYCLE   = 12'hB00,
        ADDR_MCYCLEH  = 12'hB80,
        ADDR_CYCLE    = 12'hC00,
        ADDR_TIME     = 12'hC01,
        ADDR_CYCLEH   = 12'hC80,
        ADDR_TIMEH    = 12'hC81
    } csr_addr_e;

    typedef enum logic [31:0] {
        CAUSE_INST_MISALIGNED  = 32'd0,
        CAUSE_INST_FAULT       = 32'd1,
        CAUSE_ILLEGAL_INST     = 32'd2,
        CAUSE_BREAKPOINT       = 32'd3,
        CAUSE_LOAD_MISALIGNED  = 32'd4,
        CAUSE_LOAD_FAULT       = 32'd5,
        CAUSE_STORE_MISALIGNED = 32'd6,
        CAUSE_STORE_FAULT      = 32'd7,
        CAUSE_ECALL_U          = 32'd8,
        CAUSE_ECALL_M          = 32'd11,
        // Interrupts carry bit 31
        CAUSE_IRQ_M_SOFT       = 32'h8000_0003,
        CAUSE_IRQ_M_TIMER      = 32'h8000_0007,
        CAUSE_IRQ_M_EXT        = 32'h8000_000B
    } trap_cause_e;

    typedef enum logic [1:0] {
        TVEC_DIRECT   = 2'd0,
        TVEC_VECTORED = 2'd1
    } tvec_mode_e;

endpackage

// File: verilog/csr_if.sv
`timescale 1ns/10ps
`include "csr_unit_cfg.svh"

// Decoded command, one cycle per instruction
interface csr_cmd_if;
    logic                   valid;
    csr_pkg::csr_cmd_e      cmd;
    logic [`CSR_ADDR_W-1:0] addr;
    logic [`CSR_XLEN-1:0]   wdata;
    logic                   we;
    logic                   illegal;

    modport decoder (output valid, cmd, addr, wdata, we, illegal);
    modport trap    (input valid, cmd, illegal);
    modport regfile (input valid, addr, wdata, we);
endinterface

// Architectural machine state
interface csr_state_if;
    csr_pkg::priv_mode_e  mode;
    logic                 mstatus_mie;
    logic                 mstatus_mpie;
    csr_pkg::priv_mode_e  mstatus_mpp;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mtval;
    // Bit order is {external, timer, software}
    logic [2:0]           mie;
    logic [2:0]           mip;

    modport regfile (output mode, mstatus_mie, mstatus_mpie, mstatus_mpp, mtvec, mepc,
                     mscratch, mcause, mtval, mie, mip);
    modport trap    (input mode, mstatus_mie, mtvec, mepc, mie, mip);
    modport reader  (input mode, mstatus_mie, mstatus_mpie, mstatus_mpp, mtvec, mepc,
                     mscratch, mcause, mtval, mie, mip);
endinterface

// Trap and MRET decision for the current command
interface csr_trap_if;
    logic                   take;
    logic                   mret;
    csr_pkg::trap_cause_e   cause;
    logic [`CSR_XLEN-1:0]   epc;
    logic [`CSR_XLEN-1:0]   tval;
    logic                   tval_we;
    logic [`CSR_XLEN-1:0]   target;

    modport trap    (output take, mret, cause, epc, tval, tval_we, target);
    modport regfile (input take, mret, cause, epc, tval, tval_we);
    modport decoder (input take);
    modport reader  (input take, mret, target);
endinterface

// File: verilog/csr_decode.sv
`timescale 1ns/10ps
`include "csr_unit_cfg.svh"

module csr_decode (
    input  logic                   valid,
    input  csr_pkg::csr_cmd_e      cmd,
    input  logic [`CSR_ADDR_W-1:0] csr_addr,
    input  logic [`CSR_XLEN-1:0]   operand,
    csr_cmd_if.decoder             cmd_bus,
    csr_state_if.reader            state,
    csr_trap_if.decoder            trap,
    input  logic [`CSR_XLEN-1:0]   read_value
);

    logic is_access;
    logic is_write;
    logic priv_fault;
    logic ro_fault;
    logic mret_fault;

    assign is_access = (cmd == csr_pkg::CMD_W) || (cmd == csr_pkg::CMD_S) ||
                       (cmd == csr_pkg::CMD_C);

    // Set or clear with an empty mask is a pure read
    assign is_write = (cmd == csr_pkg::CMD_W) || (is_access && (operand != '0));

    // Address bits 9:8 hold the lowest level allowed to access
    assign priv_fault = is_access && (csr_addr[9:8] > state.mode);
    assign ro_fault   = is_write && (csr_addr[11:10] == 2'b11);
    assign mret_fault = (cmd == csr_pkg::CMD_MRET) && (state.mode != csr_pkg::PRIV_M);

    always_comb begin
        case (cmd)
            csr_pkg::CMD_W: cmd_bus.wdata = operand;
            csr_pkg::CMD_S: cmd_bus.wdata = read_value | operand;
            csr_pkg::CMD_C: cmd_bus.wdata = read_value & ~operand;
            default:        cmd_bus.wdata = read_value;
        endcase
    end

    assign cmd_bus.valid   = valid;
    assign cmd_bus.cmd     = cmd;
    assign cmd_bus.addr    = csr_addr;
    assign cmd_bus.illegal = valid && (priv_fault || ro_fault || mret_fault);

    // No register write when the instruction traps for any reason
    assign cmd_bus.we = valid && is_access && !cmd_bus.illegal && !trap.take;

endmodule

// File: verilog/csr_trap_ctrl.sv
`timescale 1ns/10ps
`include "csr_unit_cfg.svh"

module csr_trap_ctrl (
    csr_cmd_if.trap               cmd_bus,
    csr_state_if.trap             state,
    csr_trap_if.trap              trap,
    input  logic [`CSR_XLEN-1:0]  pc,
    input  logic [`CSR_XLEN-1:0]  inst,
    input  logic [`CSR_XLEN-1:0]  mem_addr,
    input  logic                  expt_valid,
    input  logic [`CSR_XLEN-1:0]  expt_cause
);

    logic                 raise_expt;
    logic                 raise_intr;
    logic                 take;
    logic [2:0]           irq_pend;
    logic [`CSR_XLEN-1:0] tvec_base;
    csr_pkg::trap_cause_e expt_code;
    csr_pkg::trap_cause_e intr_code;

    assign irq_pend = state.mip & state.mie;

    assign raise_expt = cmd_bus.valid &&
                        (expt_valid || cmd_bus.illegal || (cmd_bus.cmd == csr_pkg::CMD_ECALL));

    // U mode is always interruptible, M mode only with mstatus.mie
    assign raise_intr = cmd_bus.valid && (irq_pend != 3'b000) &&
                        ((state.mode == csr_pkg::PRIV_U) || state.mstatus_mie);

    assign take = raise_expt || raise_intr;

    // Earlier stages win over faults found here
    always_comb begin
        if (expt_valid) begin
            expt_code = csr_pkg::trap_cause_e'(expt_cause);
        end else if (cmd_bus.illegal) begin
            expt_code = csr_pkg::CAUSE_ILLEGAL_INST;
        end else if (state.mode == csr_pkg::PRIV_U) begin
            expt_code = csr_pkg::CAUSE_ECALL_U;
        end else begin
            expt_code = csr_pkg::CAUSE_ECALL_M;
        end
    end

    // External, then software, then timer
    always_comb begin
        if (irq_pend[2]) begin
            intr_code = csr_pkg::CAUSE_IRQ_M_EXT;
        end else if (irq_pend[0]) begin
            intr_code = csr_pkg::CAUSE_IRQ_M_SOFT;
        end else begin
            intr_code = csr_pkg::CAUSE_IRQ_M_TIMER;
        end
    end

    always_comb begin
        case (expt_code)
            csr_pkg::CAUSE_LOAD_MISALIGNED, csr_pkg::CAUSE_LOAD_FAULT,
            csr_pkg::CAUSE_STORE_MISALIGNED, csr_pkg::CAUSE_STORE_FAULT:
                trap.tval = mem_addr;
            csr_pkg::CAUSE_ILLEGAL_INST:
                trap.tval = inst;
            csr_pkg::CAUSE_INST_MISALIGNED, csr_pkg::CAUSE_INST_FAULT,
            csr_pkg::CAUSE_BREAKPOINT:
                trap.tval = pc;
            default:
                trap.tval = '0;
        endcase
    end

    assign tvec_base = {state.mtvec[`CSR_XLEN-1:2], 2'b00};

    // MRET return target, vectored interrupt target, or plain base
    always_comb begin
        if (!take) begin
            trap.target = state.mepc;
        end else if (!raise_expt &&
                     (csr_pkg::tvec_mode_e'(state.mtvec[1:0]) == csr_pkg::TVEC_VECTORED)) begin
            trap.target = tvec_base + {intr_code[`CSR_XLEN-3:0], 2'b00};
        end else begin
            trap.target = tvec_base;
        end
    end

    assign trap.take    = take;
    assign trap.mret    = cmd_bus.valid && (cmd_bus.cmd == csr_pkg::CMD_MRET) && !take;
    assign trap.cause   = raise_expt ? expt_code : intr_code;
    assign trap.epc     = pc;
    assign trap.tval_we = raise_expt;

endmodule

// File: verilog/csr_regfile.sv
`timescale 1ns/10ps
`include "csr_unit_cfg.svh"

module csr_regfile (
    input  logic        clk,
    input  logic        rst_n,
    csr_cmd_if.regfile  cmd_bus,
    csr_trap_if.regfile trap,
    csr_state_if.regfile state,
    input  logic        irq_external,
    input  logic        irq_timer,
    input  logic        irq_software
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state.mode         <= csr_pkg::PRIV_M;
            state.mstatus_mie  <= 1'b0;
            state.mstatus_mpie <= 1'b0;
            state.mstatus_mpp  <= csr_pkg::PRIV_U;
            state.mtvec        <= '0;
            state.mepc         <= '0;
            state.mscratch     <= '0;
            state.mcause       <= '0;
            state.mtval        <= '0;
            state.mie          <= 3'b000;
            state.mip          <= 3'b000;
        end else begin
            // Pending bits follow the interrupt lines
            state.mip <= {irq_external, irq_timer, irq_software};

            if (trap.take) begin
                state.mode         <= csr_pkg::PRIV_M;
                state.mepc         <= trap.epc;
                state.mcause      <= trap.cause;
                state.mstatus_mpie <= state.mstatus_mie;
                state.mstatus_mie  <= 1'b0;
                state.mstatus_mpp  <= state.mode;
                if (trap.tval_we) begin
                    state.mtval <= trap.tval;
                end
            end else if (trap.mret) begin
                state.mode         <= state.mstatus_mpp;
                state.mstatus_mie  <= state.mstatus_mpie;
                state.mstatus_mpie <= 1'b1;
                state.mstatus_mpp  <= csr_pkg::PRIV_U;
            end else if (cmd_bus.valid && cmd_bus.we) begin
                case (csr_pkg::csr_addr_e'(cmd_bus.addr))
                    csr_pkg::ADDR_MSTATUS: begin
                        state.mstatus_mie  <= cmd_bus.wdata[3];
                        state.mstatus_mpie <= cmd_bus.wdata[7];
                        // Only U and M are kept, any other level reads back as U
                        state.mstatus_mpp  <= (cmd_bus.wdata[12:11] == 2'b11) ?
                                              csr_pkg::PRIV_M : csr_pkg::PRIV_U;
                    end
                    csr_pkg::ADDR_MIE: begin
                        state.mie <= {cmd_bus.wdata[11], cmd_bus.wdata[7], cmd_bus.wdata[3]};
                    end
                    csr_pkg::ADDR_MTVEC: begin
                        // Mode field keeps its low bit only
                        state.mtvec <= {cmd_bus.wdata[`CSR_XLEN-1:2], 1'b0, cmd_bus.wdata[0]};
                    end
                    csr_pkg::ADDR_MSCRATCH: state.mscratch <= cmd_bus.wdata;
                    csr_pkg::ADDR_MEPC: begin
                        state.mepc <= {cmd_bus.wdata[`CSR_XLEN-1:2], 2'b00};
                    end
                    csr_pkg::ADDR_MCAUSE:   state.mcause   <= cmd_bus.wdata;
                    csr_pkg::ADDR_MTVAL:    state.mtval    <= cmd_bus.wdata;
                    // misa, mip and the counters are read-only here
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// File: verilog/csr_read_port.sv
`timescale 1ns/10ps
`include "csr_unit_cfg.svh"

module csr_read_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid,
    input  logic [`CSR_ADDR_W-1:0] csr_addr,
    csr_state_if.reader            state,
    csr_trap_if.reader             trap,
    output logic [`CSR_XLEN-1:0]   read_value,
    output logic [`CSR_XLEN-1:0]   rdata,
    output logic                   redirect,
    output logic                   trap_taken,
    output logic [`CSR_XLEN-1:0]   redirect_pc
);

    localparam int DIV_W = (`CSR_TIME_DIV > 1) ? $clog2(`CSR_TIME_DIV) : 1;

    logic [`CSR_COUNTER_W-1:0] cycle_cnt;
    logic [`CSR_COUNTER_W-1:0] time_cnt;
    logic [DIV_W-1:0]          div_cnt;
    logic [`CSR_XLEN-1:0]      mstatus_word;
    logic [`CSR_XLEN-1:0]      mie_word;
    logic [`CSR_XLEN-1:0]      mip_word;

    // Both counters start from zero on the first edge out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
            time_cnt  <= '0;
            div_cnt   <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            if (div_cnt == DIV_W'(`CSR_TIME_DIV - 1)) begin
                div_cnt  <= '0;
                time_cnt <= time_cnt + 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    assign mstatus_word = {19'b0, state.mstatus_mpp, 3'b0, state.mstatus_mpie,
                           3'b0, state.mstatus_mie, 3'b0};
    assign mie_word = {20'b0, state.mie[2], 3'b0, state.mie[1], 3'b0, state.mie[0], 3'b0};
    assign mip_word = {20'b0, state.mip[2], 3'b0, state.mip[1], 3'b0, state.mip[0], 3'b0};

    always_comb begin
        case (csr_pkg::csr_addr_e'(csr_addr))
            csr_pkg::ADDR_MSTATUS:  read_value = mstatus_word;
            csr_pkg::ADDR_MISA:     read_value = `CSR_MISA_VALUE;
            csr_pkg::ADDR_MIE:      read_value = mie_word;
            csr_pkg::ADDR_MTVEC:    read_value = state.mtvec;
            csr_pkg::ADDR_MSCRATCH: read_value = state.mscratch;
            csr_pkg::ADDR_MEPC:     read_value = state.mepc;
            csr_pkg::ADDR_MCAUSE:   read_value = state.mcause;
            csr_pkg::ADDR_MTVAL:    read_value = state.mtval;
            csr_pkg::ADDR_MIP:      read_value = mip_word;
            csr_pkg::ADDR_MCYCLE,
            csr_pkg::ADDR_CYCLE:    read_value = cycle_cnt[`CSR_XLEN-1:0];
            csr_pkg::ADDR_MCYCLEH,
            csr_pkg::ADDR_CYCLEH:   read_value = cycle_cnt[`CSR_COUNTER_W-1:`CSR_XLEN];
            csr_pkg::ADDR_TIME:     read_value = time_cnt[`CSR_XLEN-1:0];
            csr_pkg::ADDR_TIMEH:    read_value = time_cnt[`CSR_COUNTER_W-1:`CSR_XLEN];
            default:                read_value = '0;
        endcase
    end

    // Results hold until the next command, the strobes last one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata       <= '0;
            redirect    <= 1'b0;
            trap_taken  <= 1'b0;
            redirect_pc <= '0;
        end else begin
            redirect   <= valid && (trap.take || trap.mret);
            trap_taken <= valid && trap.take;
            if (valid) begin
                // A trapped instruction returns no data
                rdata       <= trap.take ? '0 : read_value;
                redirect_pc <= (trap.take || trap.mret) ? trap.target : '0;
            end
        end
    end

endmodule

// File: verilog/csr_unit.sv
`timescale 1ns/10ps
`include "csr_unit_cfg.svh"

module csr_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid,
    input  logic [2:0]             cmd,
    input  logic [`CSR_ADDR_W-1:0] csr_addr,
    input  logic [`CSR_XLEN-1:0]   operand,
    input  logic [`CSR_XLEN-1:0]   pc,
    input  logic [`CSR_XLEN-1:0]   inst,
    input  logic                   expt_valid,
    input  logic [`CSR_XLEN-1:0]   expt_cause,
    input  logic [`CSR_XLEN-1:0]   mem_addr,
    input  logic                   irq_external,
    input  logic                   irq_timer,
    input  logic                   irq_software,
    output logic [`CSR_XLEN-1:0]   rdata,
    output logic                   redirect,
    output logic                   trap_taken,
    output logic [`CSR_XLEN-1:0]   redirect_pc,
    output logic [1:0]             priv_mode
);

    // Current word at csr_addr, before this edge's update
    logic [`CSR_XLEN-1:0] read_value;

    csr_cmd_if   cmd_bus ();
    csr_state_if state ();
    csr_trap_if  trap ();

    csr_decode decode_i (
        .valid      (valid),
        .cmd        (csr_pkg::csr_cmd_e'(cmd)),
        .csr_addr   (csr_addr),
        .operand    (operand),
        .cmd_bus    (cmd_bus.decoder),
        .state      (state.reader),
        .trap       (trap.decoder),
        .read_value (read_value)
    );

    csr_trap_ctrl trap_ctrl_i (
        .cmd_bus    (cmd_bus.trap),
        .state      (state.trap),
        .trap       (trap.trap),
        .pc         (pc),
        .inst       (inst),
        .mem_addr   (mem_addr),
        .expt_valid (expt_valid),
        .expt_cause (expt_cause)
    );

    csr_regfile regfile_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_bus      (cmd_bus.regfile),
        .trap         (trap.regfile),
        .state        (state.regfile),
        .irq_external (irq_external),
        .irq_timer    (irq_timer),
        .irq_software (irq_software)
    );

    csr_read_port read_port_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid       (valid),
        .csr_addr    (csr_addr),
        .state       (state.reader),
        .trap        (trap.reader),
        .read_value  (read_value),
        .rdata       (rdata),
        .redirect    (redirect),
        .trap_taken  (trap_taken),
        .redirect_pc (redirect_pc)
    );

    assign priv_mode = state.mode;

endmodule

// File: dv/csr_unit_tb.sv
`timescale 1ns/10ps
`include "csr_unit_cfg.svh"

module csr_unit_tb;

    // Sixteen words per stimulus line
    localparam int FIELDS    = 16;
    localparam int MAX_LINES = 64;

    logic                   clk;
    logic                   rst_n;
    logic                   valid;
    logic [2:0]             cmd;
    logic [`CSR_ADDR_W-1:0] csr_addr;
    logic [`CSR_XLEN-1:0]   operand;
    logic [`CSR_XLEN-1:0]   pc;
    logic [`CSR_XLEN-1:0]   inst;
    logic                   expt_valid;
    logic [`CSR_XLEN-1:0]   expt_cause;
    logic [`CSR_XLEN-1:0]   mem_addr;
    logic                   irq_external;
    logic                   irq_timer;
    logic                   irq_software;
    logic [`CSR_XLEN-1:0]   rdata;
    logic                   redirect;
    logic                   trap_taken;
    logic [`CSR_XLEN-1:0]   redirect_pc;
    logic [1:0]             priv_mode;

    logic [31:0] stim [0:FIELDS*MAX_LINES-1];
    int          line_count;
    int          cycle_count;

    // Expected privilege mode and mstatus.mpp
    logic [1:0]  model_mode;
    logic [1:0]  model_mpp;

    csr_unit csr_unit_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid        (valid),
        .cmd          (cmd),
        .csr_addr     (csr_addr),
        .operand      (operand),
        .pc           (pc),
        .inst         (inst),
        .expt_valid   (expt_valid),
        .expt_cause   (expt_cause),
        .mem_addr     (mem_addr),
        .irq_external (irq_external),
        .irq_timer    (irq_timer),
        .irq_software (irq_software),
        .rdata        (rdata),
        .redirect     (redirect),
        .trap_taken   (trap_taken),
        .redirect_pc  (redirect_pc),
        .priv_mode    (priv_mode)
    );

    always #10 clk = ~clk;

    // Cycles counted from reset release
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count > line_count + 20) begin
                $display("Timeout: the run did not end within %0d cycles", line_count + 20);
                $display("TEST FAILED");
                $fatal(1, "simulation stopped by the cycle limit");
            end
        end
    end

    task automatic check_equal(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic drive_line(input int idx);
        int base;
        base = idx * FIELDS;
        valid        <= stim[base][0];
        cmd          <= stim[base+1][2:0];
        csr_addr     <= stim[base+2][`CSR_ADDR_W-1:0];
        operand      <= stim[base+3];
        pc           <= stim[base+4];
        inst         <= stim[base+5];
        expt_valid   <= stim[base+6][0];
        expt_cause   <= stim[base+7];
        mem_addr     <= stim[base+8];
        irq_external <= stim[base+9][0];
        irq_timer    <= stim[base+10][0];
        irq_software <= stim[base+11][0];
    endtask

    task automatic drive_idle();
        valid        <= 1'b0;
        cmd          <= 3'd0;
        expt_valid   <= 1'b0;
        irq_external <= 1'b0;
        irq_timer    <= 1'b0;
        irq_software <= 1'b0;
    endtask

    // Mode after the command on line idx, from trap entry, MRET and mstatus writes
    task automatic predict_mode(input int idx);
        int         base;
        logic [1:0] mpp_bits;
        base     = idx * FIELDS;
        mpp_bits = model_mpp;
        if (stim[base][0] && stim[base+14][0]) begin
            model_mpp  = model_mode;
            model_mode = csr_pkg::PRIV_M;
        end else if (stim[base][0] && (stim[base+1][2:0] == csr_pkg::CMD_MRET)) begin
            model_mode = model_mpp;
            model_mpp  = csr_pkg::PRIV_U;
        end else if (stim[base][0] && (stim[base+2][`CSR_ADDR_W-1:0] == csr_pkg::ADDR_MSTATUS)) begin
            case (stim[base+1][2:0])
                csr_pkg::CMD_W: mpp_bits = stim[base+3][12:11];
                csr_pkg::CMD_S: mpp_bits = model_mpp | stim[base+3][12:11];
                csr_pkg::CMD_C: mpp_bits = model_mpp & ~stim[base+3][12:11];
                default:        mpp_bits = model_mpp;
            endcase
            // Only U and M exist
            model_mpp = (mpp_bits == 2'b11) ? csr_pkg::PRIV_M : csr_pkg::PRIV_U;
        end
    endtask

    // Outputs of the command on line idx
    task automatic check_outputs(input int idx);
        int   base;
        logic exp_redirect;
        base = idx * FIELDS;
        if (stim[base+12][0]) begin
            // A trap or an untrapped MRET redirects
            exp_redirect = stim[base+14][0] ||
                           (stim[base][0] && (stim[base+1][2:0] == csr_pkg::CMD_MRET));
            predict_mode(idx);
            check_equal($sformatf("line %0d rdata", idx), rdata, stim[base+13]);
            check_equal($sformatf("line %0d trap_taken", idx), {31'b0, trap_taken},
                        stim[base+14]);
            check_equal($sformatf("line %0d redirect", idx), {31'b0, redirect},
                        {31'b0, exp_redirect});
            check_equal($sformatf("line %0d redirect_pc", idx), redirect_pc, stim[base+15]);
            check_equal($sformatf("line %0d priv_mode", idx), {30'b0, priv_mode},
                        {30'b0, model_mode});
        end
    endtask

    initial begin
        int idx;
        clk          = 1'b0;
        rst_n        = 1'b0;
        valid        = 1'b0;
        cmd          = 3'd0;
        csr_addr     = '0;
        operand      = '0;
        pc           = '0;
        inst         = '0;
        expt_valid   = 1'b0;
        expt_cause   = '0;
        mem_addr     = '0;
        irq_external = 1'b0;
        irq_timer    = 1'b0;
        irq_software = 1'b0;
        cycle_count  = 0;
        line_count   = 0;
        model_mode   = csr_pkg::PRIV_M;
        model_mpp    = csr_pkg::PRIV_U;

        $readmemh("dv/csr_unit_stimulus.txt", stim);
        // The first unfilled record ends the stimulus
        while (line_count < MAX_LINES && !$isunknown(stim[line_count*FIELDS])) begin
            line_count++;
        end

        if (line_count == 0) begin
            $display("No stimulus lines could be read from dv/csr_unit_stimulus.txt");
            $display("TEST FAILED");
            $fatal(1, "missing stimulus");
        end else begin
            repeat (8) @(posedge clk);
            rst_n <= 1'b1;
            drive_line(0);
            for (idx = 0; idx < line_count; idx++) begin
                // Line idx is sampled at this edge
                @(posedge clk);
                if (idx + 1 < line_count) begin
                    drive_line(idx + 1);
                end else begin
                    drive_idle();
                end
                @(negedge clk);
                check_outputs(idx);
            end
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// File: dv/csr_unit_stimulus.txt
// valid cmd addr operand pc inst expt_valid expt_cause mem_addr irq_ext irq_tmr irq_sw
// chk rdata trap_taken redirect_pc (chk 0 leaves the line unchecked)
1 1 340 12345678 00000000 00000000 0 00000000 00000000 0 0 0 1 00000000 0 00000000
1 2 340 000000f0 00000000 00000000 0 00000000 00000000 0 0 0 1 12345678 0 00000000
1 3 340 12000008 00000000 00000000 0 00000000 00000000 0 0 0 1 123456f8 0 00000000
1 2 340 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 003456f0 0 00000000
1 1 341 00001237 00000000 00000000 0 00000000 00000000 0 0 0 1 00000000 0 00000000
1 2 341 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 00001234 0 00000000
1 1 305 00000100 00000000 00000000 0 00000000 00000000 0 0 0 1 00000000 0 00000000
1 1 300 00000008 00000000 00000000 0 00000000 00000000 0 0 0 1 00000000 0 00000000
1 0 000 00000000 00000400 00000000 1 00000005 0000abc0 0 0 0 1 00000000 1 00000100
1 2 342 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 00000005 0 00000000
1 2 343 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 0000abc0 0 00000000
1 2 341 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 00000400 0 00000000
1 2 300 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 00001880 0 00000000
1 1 300 00000080 00000000 00000000 0 00000000 00000000 0 0 0 1 00001880 0 00000000
1 1 341 00002000 00000000 00000000 0 00000000 00000000 0 0 0 1 00000400 0 00000000
1 5 000 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 00000000 0 00002000
1 2 c00 00000000 00002000 c0002573 0 00000000 00000000 0 0 0 1 00000010 0 00000000
1 2 340 00000000 00002004 34002573 0 00000000 00000000 0 0 0 1 00000000 1 00000100
1 2 343 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 34002573 0 00000000
1 2 342 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 00000002 0 00000000
1 5 000 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 00000000 0 00002004
1 4 000 00000000 00002008 00000073 0 00000000 00000000 0 0 0 1 00000000 1 00000100
1 2 342 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 00000008 0 00000000
1 1 305 00000201 00000000 00000000 0 00000000 00000000 0 0 0 1 00000100 0 00000000
1 1 304 00000800 00000000 00000000 0 00000000 00000000 0 0 0 1 00000000 0 00000000
1 1 300 00000008 00000000 00000000 0 00000000 00000000 0 1 0 1 00000080 0 00000000
1 2 340 00000000 00000000 00000000 0 00000000 00000000 1 1 0 1 003456f0 0 00000000
1 2 340 00000000 00003000 00000000 0 00000000 00000000 1 1 0 1 00000000 1 0000022c
1 2 342 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 8000000b 0 00000000
1 2 c00 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 0000001d 0 00000000
1 2 b80 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 00000000 0 00000000
1 2 c01 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 00000007 0 00000000
1 1 c00 00000005 00003004 c0029073 0 00000000 00000000 0 0 0 1 00000000 1 00000200
1 2 343 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 c0029073 0 00000000
1 2 301 00000000 00000000 00000000 0 00000000 00000000 0 0 0 1 40100100 0 00000000
0 0 000 00000000 00000000 00000000 0 00000000 00000000 0 0 0 0 00000000 0 00000000

// File: csr_unit.f
+incdir+include
verilog/csr_pkg.sv
verilog/csr_if.sv
verilog/csr_decode.sv
verilog/csr_trap_ctrl.sv
verilog/csr_regfile.sv
verilog/csr_read_port.sv
verilog/csr_unit.sv
dv/csr_unit_tb.sv

// File: Bender.yml
package:
  name: csr_unit

export_include_dirs:
  - include

sources:
  - files:
      - verilog/csr_pkg.sv
      - verilog/csr_if.sv
      - verilog/csr_decode.sv
      - verilog/csr_trap_ctrl.sv
      - verilog/csr_regfile.sv
      - verilog/csr_read_port.sv
      - verilog/csr_unit.sv
  - target: test
    files:
      - dv/csr_unit_tb.sv
